// ==== tb.f ====
logic/backend_pkg.sv
logic/data_memory.sv
logic/mem_stage.sv
logic/regfile_writeback.sv
logic/operand_bypass.sv
logic/mem_wb_backend.sv
+incdir+tb
tb/tb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the back-end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_backend \
    --Mdir obj_dir \
    -o sim_backend

# a failing run still leaves its log for the check below
./obj_dir/sim_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tb/tb_tasks.svh ====
`ifndef tb_tasks_svh
`define tb_tasks_svh

// one instruction slot, driven on the falling edge
task automatic drive_slot(input mem_op_t op, input logic [31:0] result,
                          input logic [31:0] sdata, input logic [4:0] rd,
                          input logic rw, input logic [4:0] r1, input logic [4:0] r2,
                          input logic stl);
    @(negedge clk);
    ex_valid      = 1'b1;
    ex_pc         = pc_next;
    ex_alu_result = result;
    ex_store_data = sdata;
    ex_rd         = rd;
    ex_mem_op     = op;
    ex_reg_write  = rw;
    stall         = stl;
    rs1_addr      = r1;
    rs2_addr      = r2;
    pc_next       = pc_next + 32'd4;
endtask

task automatic bubble(input logic [4:0] r1, input logic [4:0] r2);
    @(negedge clk);
    ex_valid     = 1'b0;
    ex_mem_op    = mem_none;
    ex_reg_write = 1'b0;
    stall        = 1'b0;
    rs1_addr     = r1;
    rs2_addr     = r2;
endtask

// rs1 on the new rd hits execute forwarding, rs2 on the previous one hits writeback
task automatic issue_alu(input logic [4:0] rd, input logic [31:0] val);
    drive_slot(mem_none, val, 32'd0, rd, 1'b1, rd, last_rd, 1'b0);
    last_rd = rd;
endtask

task automatic issue_store(input mem_op_t op, input logic [31:0] addr,
                           input logic [31:0] data, input logic stl);
    drive_slot(op, addr, data, 5'd0, 1'b0, rand_reg(), rand_reg(), stl);
endtask

// every other load reads a neighbour of rd on rs1, so the hazard flag sees both cases
task automatic issue_load(input mem_op_t op, input logic [31:0] addr, input logic [4:0] rd);
    drive_slot(op, addr, 32'd0, rd, 1'b1, rd ^ {4'd0, pc_next[2]}, rand_reg(), 1'b0);
    last_rd = rd;
endtask

`endif

// ==== tb/tb_backend.sv ====
`default_nettype none

module tb_backend;

    import backend_pkg::*;

    localparam int n_alu    = 40;
    localparam int n_rounds = 24;
    localparam int n_stall  = 10;
    localparam int total_ops = 2 * 16 + n_alu + 18 * n_rounds + 3 * n_stall + 4;
    localparam int cycle_limit = 2 * total_ops + 100 + 8;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        ex_valid, ex_reg_write, stall;
    logic [31:0] ex_pc, ex_alu_result, ex_store_data;
    logic [4:0]  ex_rd, rs1_addr, rs2_addr;
    mem_op_t     ex_mem_op;
    wire  [31:0] rs1_data, rs2_data, wb_pc, wb_data;
    wire  [4:0]  wb_rd;
    wire         load_use_stall, wb_valid, wb_reg_write;

    logic [31:0] pc_next = 32'h100;
    logic [4:0]  last_rd = 5'd0;
    int          cycles = 0;
    int          errors = 0;

    // reference model state
    logic [7:0]  model_mem [4096];
    logic [31:0] model_regs [32];
    logic        m_wb_valid, m_wb_rw;
    logic [4:0]  m_wb_rd;
    logic [31:0] m_wb_data, m_wb_pc;

    always #2 clk = ~clk;

    mem_wb_backend uut (.*);

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic logic loads(input mem_op_t op);
        return op == mem_lb || op == mem_lh || op == mem_lw || op == mem_lbu || op == mem_lhu;
    endfunction

    function automatic logic [31:0] load_value(input mem_op_t op, input logic [11:0] a);
        logic [7:0] b0, b1, b2, b3;
        b0 = model_mem[a];
        b1 = model_mem[a + 12'd1];
        b2 = model_mem[a + 12'd2];
        b3 = model_mem[a + 12'd3];
        case (op)
            mem_lb:  return {{24{b0[7]}}, b0};
            mem_lbu: return {24'd0, b0};
            mem_lh:  return {{16{b1[7]}}, b1, b0};
            mem_lhu: return {16'd0, b1, b0};
            mem_lw:  return {b3, b2, b1, b0};
            default: return 32'd0;
        endcase
    endfunction

    // newest producer first, x0 fixed at zero
    function automatic logic [31:0] forward(input logic [4:0] a, input logic [31:0] rf,
                                            input logic ex_ok, input logic [4:0] ex_dst,
                                            input logic [31:0] ex_val, input logic wb_ok,
                                            input logic [4:0] wb_dst,
                                            input logic [31:0] wb_val);
        if (a == 5'd0)
            return 32'd0;
        else if (ex_ok && ex_dst == a)
            return ex_val;
        else if (wb_ok && wb_dst == a)
            return wb_val;
        return rf;
    endfunction

    `include "tb_tasks.svh"

    wire        take   = ex_valid && !stall;
    wire        ex_ok  = ex_valid && ex_reg_write && !loads(ex_mem_op);
    wire        wb_ok  = m_wb_valid && m_wb_rw;
    wire [31:0] exp_rs1 = forward(rs1_addr, model_regs[rs1_addr], ex_ok, ex_rd, ex_alu_result,
                                  wb_ok, m_wb_rd, m_wb_data);
    wire [31:0] exp_rs2 = forward(rs2_addr, model_regs[rs2_addr], ex_ok, ex_rd, ex_alu_result,
                                  wb_ok, m_wb_rd, m_wb_data);
    wire        exp_luse = ex_valid && loads(ex_mem_op) && ex_rd != 5'd0
                         && (ex_rd == rs1_addr || ex_rd == rs2_addr);

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) model_regs[i] <= 32'd0;
            for (int i = 0; i < 4096; i++) model_mem[i] <= 8'd0;
            m_wb_valid <= 1'b0;
            m_wb_rw    <= 1'b0;
            m_wb_rd    <= 5'd0;
            m_wb_data  <= 32'd0;
            m_wb_pc    <= 32'd0;
        end else begin
            if (wb_ok && m_wb_rd != 5'd0)
                model_regs[m_wb_rd] <= m_wb_data;
            if (take) begin
                m_wb_valid <= 1'b1;
                m_wb_rw    <= ex_reg_write;
                m_wb_rd    <= ex_rd;
                m_wb_pc    <= ex_pc;
                m_wb_data  <= loads(ex_mem_op) ? load_value(ex_mem_op, ex_alu_result[11:0])
                                               : ex_alu_result;
                case (ex_mem_op)
                    mem_sb: model_mem[ex_alu_result[11:0]] <= ex_store_data[7:0];
                    mem_sh: begin
                        model_mem[ex_alu_result[11:0]]         <= ex_store_data[7:0];
                        model_mem[ex_alu_result[11:0] + 12'd1] <= ex_store_data[15:8];
                    end
                    mem_sw: begin
                        for (int b = 0; b < 4; b++)
                            model_mem[ex_alu_result[11:0] + 12'(b)] <= ex_store_data[b*8 +: 8];
                    end
                    default: ;
                endcase
            end else begin
                m_wb_valid <= 1'b0;  // fields held like the stage
            end
        end
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "model mismatch");
    endtask

    chk_wb_valid: assert property (@(posedge clk) disable iff (!reset_n) wb_valid == m_wb_valid)
        else report("wb_valid", 32'($sampled(m_wb_valid)), 32'($sampled(wb_valid)));
    chk_wb_rw: assert property (@(posedge clk) disable iff (!reset_n) wb_reg_write == m_wb_rw)
        else report("wb_reg_write", 32'($sampled(m_wb_rw)), 32'($sampled(wb_reg_write)));
    chk_wb_rd: assert property (@(posedge clk) disable iff (!reset_n) wb_rd == m_wb_rd)
        else report("wb_rd", 32'($sampled(m_wb_rd)), 32'($sampled(wb_rd)));
    chk_wb_pc: assert property (@(posedge clk) disable iff (!reset_n) wb_pc == m_wb_pc)
        else report("wb_pc", $sampled(m_wb_pc), $sampled(wb_pc));
    chk_wb_data: assert property (@(posedge clk) disable iff (!reset_n) wb_data == m_wb_data)
        else report("wb_data", $sampled(m_wb_data), $sampled(wb_data));
    chk_rs1: assert property (@(posedge clk) disable iff (!reset_n) rs1_data == exp_rs1)
        else report("rs1_data", $sampled(exp_rs1), $sampled(rs1_data));
    chk_rs2: assert property (@(posedge clk) disable iff (!reset_n) rs2_data == exp_rs2)
        else report("rs2_data", $sampled(exp_rs2), $sampled(rs2_data));
    chk_luse: assert property (@(posedge clk) disable iff (!reset_n) load_use_stall == exp_luse)
        else report("load_use_stall", 32'($sampled(exp_luse)), 32'($sampled(load_use_stall)));
    // bubble follows a stalled cycle
    chk_stall_bubble: assert property (@(posedge clk) disable iff (!reset_n) stall |=> !wb_valid)
        else report("wb_valid", 32'd0, 32'($sampled(wb_valid)));

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] base, data, r;
        void'($urandom(65));
        reset_n = 1'b0;
        ex_valid = 1'b0;
        ex_pc = 32'd0;
        ex_alu_result = 32'd0;
        ex_store_data = 32'd0;
        ex_rd = 5'd0;
        ex_mem_op = mem_none;
        ex_reg_write = 1'b0;
        stall = 1'b0;
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        repeat (8) @(posedge clk);
        @(negedge clk) reset_n = 1'b1;

        for (int i = 0; i < 16; i++) bubble(5'(2 * i), 5'(2 * i + 1));  // all zero

        for (int i = 0; i < n_alu; i++)
            issue_alu((i % 8 == 0) ? 5'd0 : rand_reg(), $urandom);
        for (int i = 0; i < 16; i++) bubble(5'(2 * i), 5'(2 * i + 1));

        for (int i = 0; i < n_rounds; i++) begin
            r = $urandom;
            base = {20'd0, r[11:4], 4'b0000};  // room for a neighbour word
            data = $urandom;
            issue_store(mem_sw, base, data, 1'b0);
            r = $urandom;
            issue_store(mem_sb, base + {30'd0, r[1:0]}, $urandom, 1'b0);
            issue_store(mem_sh, base + {29'd0, r[2], 2'b00} + 32'd2, $urandom, 1'b0);
            for (int o = 0; o < 4; o++) begin
                issue_load(mem_lb, base + 32'(o), rand_reg());
                issue_load(mem_lbu, base + 32'(o), rand_reg());
            end
            for (int o = 0; o < 4; o += 2) begin
                issue_load(mem_lh, base + 32'(o), rand_reg());
                issue_load(mem_lhu, base + 32'(o), rand_reg());
            end
            issue_load(mem_lw, base, rand_reg());
            issue_load(mem_lw, base + 32'd4, rand_reg());
            issue_load(mem_lbu, base + 32'd7, rand_reg());
        end

        for (int i = 0; i < n_stall; i++) begin
            r = $urandom;
            base = {20'd0, r[11:2], 2'b00};
            issue_store(mem_sw, base, $urandom, 1'b1);  // held off, memory unchanged
            bubble(rand_reg(), rand_reg());
            issue_load(mem_lw, base, rand_reg());
        end

        repeat (4) bubble(rand_reg(), rand_reg());
        @(negedge clk);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/mem_wb_backend.sv ====
`default_nettype none

module mem_wb_backend (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                ex_valid,
    input  wire [backend_pkg::xlen-1:0]        ex_pc,
    input  wire [backend_pkg::xlen-1:0]        ex_alu_result,
    input  wire [backend_pkg::xlen-1:0]        ex_store_data,
    input  wire [backend_pkg::reg_addr_w-1:0]  ex_rd,
    input  wire backend_pkg::mem_op_t          ex_mem_op,
    input  wire                                ex_reg_write,
    input  wire                                stall,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs1_addr,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs2_addr,
    output wire [backend_pkg::xlen-1:0]        rs1_data,
    output wire [backend_pkg::xlen-1:0]        rs2_data,
    output wire                                load_use_stall,
    output wire                                wb_valid,
    output wire [backend_pkg::xlen-1:0]        wb_pc,
    output wire [backend_pkg::reg_addr_w-1:0]  wb_rd,
    output wire [backend_pkg::xlen-1:0]        wb_data,
    output wire                                wb_reg_write
);

    import backend_pkg::*;

    // data ram side
    wire [dmem_addr_w-1:0] mem_word_addr;
    wire [xlen-1:0]        mem_wdata;
    wire [3:0]             mem_wstrobe;
    wire [xlen-1:0]        mem_rdata;

    // writeback side
    wire                   wb_mem_to_reg;
    wire [xlen-1:0]        wb_load_data;
    wire [xlen-1:0]        wb_alu_result;
    wire [xlen-1:0]        rf_rs1_data;
    wire [xlen-1:0]        rf_rs2_data;

    mem_stage u_mem_stage (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall         (stall),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_alu_result (ex_alu_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_mem_op     (ex_mem_op),
        .ex_reg_write  (ex_reg_write),
        .mem_word_addr (mem_word_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrobe   (mem_wstrobe),
        .mem_rdata     (mem_rdata),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write),
        .wb_mem_to_reg (wb_mem_to_reg),
        .wb_load_data  (wb_load_data),
        .wb_alu_result (wb_alu_result)
    );

    data_memory u_data_memory (
        .clk       (clk),
        .word_addr (mem_word_addr),
        .wdata     (mem_wdata),
        .wstrobe   (mem_wstrobe),
        .rdata     (mem_rdata)
    );

    regfile_writeback u_regfile (
        .clk           (clk),
        .reset_n       (reset_n),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_reg_write  (wb_reg_write),
        .wb_mem_to_reg (wb_mem_to_reg),
        .wb_load_data  (wb_load_data),
        .wb_alu_result (wb_alu_result),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rf_rs1_data   (rf_rs1_data),
        .rf_rs2_data   (rf_rs2_data),
        .wb_data       (wb_data)
    );

    operand_bypass u_bypass (
        .ex_valid       (ex_valid),
        .ex_rd          (ex_rd),
        .ex_reg_write   (ex_reg_write),
        .ex_mem_op      (ex_mem_op),
        .ex_alu_result  (ex_alu_result),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_reg_write   (wb_reg_write),
        .wb_data        (wb_data),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rf_rs1_data    (rf_rs1_data),
        .rf_rs2_data    (rf_rs2_data),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .load_use_stall (load_use_stall)
    );

endmodule

`default_nettype wire

// ==== logic/operand_bypass.sv ====
`default_nettype none

module operand_bypass (
    input  wire                                ex_valid,
    input  wire [backend_pkg::reg_addr_w-1:0]  ex_rd,
    input  wire                                ex_reg_write,
    input  wire backend_pkg::mem_op_t          ex_mem_op,
    input  wire [backend_pkg::xlen-1:0]        ex_alu_result,
    input  wire                                wb_valid,
    input  wire [backend_pkg::reg_addr_w-1:0]  wb_rd,
    input  wire                                wb_reg_write,
    input  wire [backend_pkg::xlen-1:0]        wb_data,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs1_addr,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs2_addr,
    input  wire [backend_pkg::xlen-1:0]        rf_rs1_data,
    input  wire [backend_pkg::xlen-1:0]        rf_rs2_data,
    output logic [backend_pkg::xlen-1:0]       rs1_data,
    output logic [backend_pkg::xlen-1:0]       rs2_data,
    output logic                               load_use_stall
);

    import backend_pkg::*;

    logic ex_fwd_ok;  // execute result usable now
    logic wb_fwd_ok;
    logic ex_is_load;

    assign ex_is_load = is_load(ex_mem_op);
    assign ex_fwd_ok  = ex_valid && ex_reg_write && !ex_is_load;
    assign wb_fwd_ok  = wb_valid && wb_reg_write;

    // newest producer wins, x0 always zero
    function automatic logic [xlen-1:0] pick(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_val
    );
        if (addr == '0)
            return '0;
        else if (ex_fwd_ok && ex_rd == addr)
            return ex_alu_result;
        else if (wb_fwd_ok && wb_rd == addr)
            return wb_data;
        else
            return rf_val;
    endfunction

    always_comb begin
        rs1_data = pick(rs1_addr, rf_rs1_data);
        rs2_data = pick(rs2_addr, rf_rs2_data);
    end

    // load data only exists after the edge, decode has to wait
    assign load_use_stall = ex_valid && ex_is_load && (ex_rd != '0)
                          && (ex_rd == rs1_addr || ex_rd == rs2_addr);

endmodule

`default_nettype wire

// ==== logic/regfile_writeback.sv ====
`default_nettype none

module regfile_writeback (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                wb_valid,
    input  wire [backend_pkg::reg_addr_w-1:0]  wb_rd,
    input  wire                                wb_reg_write,
    input  wire                                wb_mem_to_reg,
    input  wire [backend_pkg::xlen-1:0]        wb_load_data,
    input  wire [backend_pkg::xlen-1:0]        wb_alu_result,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs1_addr,
    input  wire [backend_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic [backend_pkg::xlen-1:0]       rf_rs1_data,
    output logic [backend_pkg::xlen-1:0]       rf_rs2_data,
    output logic [backend_pkg::xlen-1:0]       wb_data
);

    import backend_pkg::*;

    localparam int num_regs = 1 << reg_addr_w;

    logic [xlen-1:0] regs [1:num_regs-1];  // x0 has no storage
    logic            wb_commit;

    assign wb_data   = wb_mem_to_reg ? wb_load_data : wb_alu_result;
    assign wb_commit = wb_valid && wb_reg_write && (wb_rd != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_commit) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // plain reads, same-cycle writes are forwarded outside
    assign rf_rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rf_rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // committed value visible one cycle after the write
    write_then_read: assert property (@(posedge clk) disable iff (!reset_n)
        wb_commit ##1 (rs1_addr == $past(wb_rd)) |-> rf_rs1_data == $past(wb_data));

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                stall,
    input  wire                                ex_valid,
    input  wire [backend_pkg::xlen-1:0]        ex_pc,
    input  wire [backend_pkg::xlen-1:0]        ex_alu_result,  // address for loads and stores
    input  wire [backend_pkg::xlen-1:0]        ex_store_data,
    input  wire [backend_pkg::reg_addr_w-1:0]  ex_rd,
    input  wire backend_pkg::mem_op_t          ex_mem_op,
    input  wire                                ex_reg_write,
    output logic [backend_pkg::dmem_addr_w-1:0] mem_word_addr,
    output logic [backend_pkg::xlen-1:0]       mem_wdata,
    output logic [3:0]                         mem_wstrobe,
    input  wire [backend_pkg::xlen-1:0]        mem_rdata,
    output logic                               wb_valid,
    output logic [backend_pkg::xlen-1:0]       wb_pc,
    output logic [backend_pkg::reg_addr_w-1:0] wb_rd,
    output logic                               wb_reg_write,
    output logic                               wb_mem_to_reg,
    output logic [backend_pkg::xlen-1:0]       wb_load_data,
    output logic [backend_pkg::xlen-1:0]       wb_alu_result
);

    import backend_pkg::*;

    logic            take;          // instruction accepted this cycle
    logic [1:0]      byte_off;
    logic [4:0]      lane_shift;    // bit offset of the addressed byte
    logic [xlen-1:0] load_shifted;
    logic [xlen-1:0] load_ext;

    assign take       = ex_valid && !stall;
    assign byte_off   = ex_alu_result[1:0];
    assign lane_shift = {byte_off, 3'b000};

    assign mem_word_addr = ex_alu_result[dmem_addr_w+1:2];
    assign mem_wdata     = ex_store_data << lane_shift;  // move store data into its lane

    always_comb begin
        mem_wstrobe = 4'b0000;
        if (take) begin
            case (ex_mem_op)
                mem_sb:  mem_wstrobe = 4'b0001 << byte_off;
                mem_sh:  mem_wstrobe = 4'b0011 << byte_off;
                mem_sw:  mem_wstrobe = 4'b1111;
                default: mem_wstrobe = 4'b0000;
            endcase
        end
    end

    // addressed byte or half lands in the low bits
    assign load_shifted = mem_rdata >> lane_shift;

    always_comb begin
        case (ex_mem_op)
            mem_lb:  load_ext = {{(xlen-8){load_shifted[7]}}, load_shifted[7:0]};
            mem_lh:  load_ext = {{(xlen-16){load_shifted[15]}}, load_shifted[15:0]};
            mem_lw:  load_ext = mem_rdata;
            mem_lbu: load_ext = {{(xlen-8){1'b0}}, load_shifted[7:0]};
            mem_lhu: load_ext = {{(xlen-16){1'b0}}, load_shifted[15:0]};
            default: load_ext = '0;  // stores and alu ops carry no load data
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid      <= 1'b0;
            wb_pc         <= '0;
            wb_rd         <= '0;
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
            wb_load_data  <= '0;
            wb_alu_result <= '0;
        end else if (take) begin
            wb_valid      <= 1'b1;
            wb_pc         <= ex_pc;
            wb_rd         <= ex_rd;
            wb_reg_write  <= ex_reg_write;
            wb_mem_to_reg <= is_load(ex_mem_op);
            wb_load_data  <= load_ext;
            wb_alu_result <= ex_alu_result;
        end else begin
            wb_valid <= 1'b0;  // bubble, held fields stay
        end
    end

    // no trap for misaligned accesses, so flag them here
    half_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (take && is_half(ex_mem_op)) |-> !ex_alu_result[0]);

    word_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (take && is_word(ex_mem_op)) |-> ex_alu_result[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/data_memory.sv ====
`default_nettype none

module data_memory (
    input  wire                                clk,
    input  wire [backend_pkg::dmem_addr_w-1:0] word_addr,
    input  wire [backend_pkg::xlen-1:0]        wdata,
    input  wire [3:0]                          wstrobe,
    output logic [backend_pkg::xlen-1:0]       rdata
);

    import backend_pkg::*;

    logic [xlen-1:0] mem [dmem_words];

    // array starts out all zero
    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wstrobe[lane]) begin
                mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

    assign rdata = mem[word_addr];  // async read, load data ready before the edge

endmodule

`default_nettype wire

// ==== logic/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int dmem_words  = 1024;
    localparam int dmem_addr_w = $clog2(dmem_words);  // word index, 10 bits

    // memory operation carried with each instruction
    typedef enum logic [3:0] {
        mem_none = 4'd0,  // alu result only
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sb   = 4'd6,
        mem_sh   = 4'd7,
        mem_sw   = 4'd8
    } mem_op_t;

    function automatic logic is_load(input mem_op_t op);
        return op inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return op inside {mem_sb, mem_sh, mem_sw};
    endfunction

    // access size groups, used by the alignment checks
    function automatic logic is_half(input mem_op_t op);
        return op inside {mem_lh, mem_lhu, mem_sh};
    endfunction

    function automatic logic is_word(input mem_op_t op);
        return op inside {mem_lw, mem_sw};
    endfunction

endpackage

`default_nettype wire
